// ==== build.f ====
+incdir+hw
hw/spi_pkg.sv
hw/spi_reg_file.sv
hw/spi_fifo.sv
hw/spi_master.sv
hw/axil_spi.sv
verif/tb_axil_spi.sv

// ==== hw/axil_spi.sv ====
// SPI controller top: register file, TX and RX FIFOs, SPI master and status flags
`timescale 1ns/1ps
`default_nettype none

module axil_spi (
    input  wire logic               clk_i,
    input  wire logic               reset_i,
    input  wire spi_pkg::axil_req_t s_axil_req_i,
    output spi_pkg::axil_rsp_t      s_axil_rsp_o,
    input  wire logic               miso_i,
    output spi_pkg::spi_port_t      spi_o
);
    import spi_pkg::*;

    spi_cfg_t    cfg;
    spi_status_t status;
    spi_stream_t tx_in;        // reg file to tx fifo
    logic        tx_in_ready;
    spi_stream_t tx_out;       // tx fifo to master
    logic        tx_out_ready;
    spi_stream_t rx_in;        // master to rx fifo
    logic        rx_in_ready;
    spi_stream_t rx_out;       // rx fifo to reg file
    logic        rx_out_ready;
    logic        block_reset;

    assign block_reset = reset_i || !cfg.enable;  // enable 0 is a soft reset

    always_comb begin
        status.rx_empty = !rx_out.tvalid;
        status.tx_empty = !tx_out.tvalid;
        status.rx_full  = !rx_in_ready;
        status.tx_full  = !tx_in_ready;
    end

    spi_reg_file i_reg_file (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .axil_req_i(s_axil_req_i),
        .axil_rsp_o(s_axil_rsp_o),
        .status_i  (status),
        .rx_i      (rx_out),
        .rx_ready_o(rx_out_ready),
        .tx_o      (tx_in),
        .tx_ready_i(tx_in_ready),
        .cfg_o     (cfg)
    );

    spi_fifo i_tx_fifo (
        .clk_i    (clk_i),
        .reset_i  (block_reset),
        .s_i      (tx_in),
        .s_ready_o(tx_in_ready),
        .m_o      (tx_out),
        .m_ready_i(tx_out_ready)
    );

    spi_master i_master (
        .clk_i    (clk_i),
        .reset_i  (block_reset),
        .cfg_i    (cfg),
        .s_i      (tx_out),
        .s_ready_o(tx_out_ready),
        .m_o      (rx_in),
        .m_ready_i(rx_in_ready),
        .miso_i   (miso_i),
        .spi_o    (spi_o)
    );

    spi_fifo i_rx_fifo (
        .clk_i    (clk_i),
        .reset_i  (block_reset),
        .s_i      (rx_in),
        .s_ready_o(rx_in_ready),
        .m_o      (rx_out),
        .m_ready_i(rx_out_ready)
    );

    // TX writes to a full fifo are dropped in the reg file, never offered
    assert property (@(posedge clk_i) disable iff (block_reset)
        tx_in.tvalid |-> tx_in_ready);

endmodule

`default_nettype wire

// ==== hw/spi_consts.svh ====
// SPI controller widths, FIFO depth, slave count, register map and register bit positions
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

`define SPI_DATA_WIDTH 8
`define SPI_FIFO_DEPTH 16      // power of two
`define SPI_SLAVE_NUM 2
`define SPI_DIV_WIDTH 8
`define SPI_WAIT_WIDTH 8

`define AXIL_ADDR_WIDTH 8
`define AXIL_DATA_WIDTH 32

`define SPI_REG_CONTROL 8'h00
`define SPI_REG_STATUS 8'h04
`define SPI_REG_DIVIDER 8'h08
`define SPI_REG_WAIT 8'h0C
`define SPI_REG_SELECT 8'h10
`define SPI_REG_TX 8'h14
`define SPI_REG_RX 8'h18
`define SPI_REG_PARAM 8'h1C
`define SPI_REG_NUM 8

`define SPI_CTRL_ENABLE 0      // CONTROL bits
`define SPI_CTRL_CPOL 1
`define SPI_CTRL_CPHA 2
`define SPI_TX_LAST 8          // last flag in a TX write
`define SPI_RX_VALID 8         // valid flag in an RX read

`endif

// ==== hw/spi_fifo.sv ====
// synchronous first-word-fall-through FIFO for stream data and tlast
`timescale 1ns/1ps
`default_nettype none
`include "spi_consts.svh"

module spi_fifo #(
    parameter int DEPTH = `SPI_FIFO_DEPTH  // power of two
) (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire spi_pkg::spi_stream_t s_i,
    output logic                      s_ready_o,
    output spi_pkg::spi_stream_t      m_o,
    input  wire logic                 m_ready_i
);
    import spi_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    spi_data_t        mem_data [DEPTH];
    logic             mem_last [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign s_ready_o = (count != (PTR_W+1)'(DEPTH));
    assign push      = s_i.tvalid && s_ready_o;
    assign pop       = m_o.tvalid && m_ready_i;

    always_comb begin
        m_o.tdata  = mem_data[rd_ptr];
        m_o.tlast  = mem_last[rd_ptr];
        m_o.tvalid = (count != '0);
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_data[wr_ptr] <= s_i.tdata;
            mem_last[wr_ptr] <= s_i.tlast;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i)
        count <= (PTR_W+1)'(DEPTH));

endmodule

`default_nettype wire

// ==== hw/spi_master.sv ====
// SPI shift engine with CPOL/CPHA, SCK divider, chip-select framing and inter-frame wait
`timescale 1ns/1ps
`default_nettype none
`include "spi_consts.svh"

module spi_master (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire spi_pkg::spi_cfg_t    cfg_i,
    input  wire spi_pkg::spi_stream_t s_i,
    output logic                      s_ready_o,
    output spi_pkg::spi_stream_t      m_o,
    input  wire logic                 m_ready_i,
    input  wire logic                 miso_i,
    output spi_pkg::spi_port_t        spi_o
);
    import spi_pkg::*;

    localparam int BIT_W = $clog2(`SPI_DATA_WIDTH);

    spi_state_e       state;
    spi_div_t         half_cnt;
    spi_wait_t        wait_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic             phase_q;     // 1 between leading and trailing edge
    spi_sel_t         sel_q;
    logic             last_q;
    logic             rx_valid_q;
    spi_data_t        tx_shift;
    spi_data_t        rx_shift;
    logic             half_done;
    logic             last_bit;
    logic             lead_edge;
    logic             trail_edge;
    logic             do_sample;
    logic             do_shift;
    logic             load;
    logic             cs_active;

    assign half_done  = (half_cnt == cfg_i.divider);
    assign last_bit   = (bit_cnt == BIT_W'(`SPI_DATA_WIDTH - 1));
    assign lead_edge  = half_done && !phase_q && (state == SETUP || state == SHIFT);
    assign trail_edge = half_done && phase_q && (state == SHIFT);

    // cpha 0 samples on leading edges, cpha 1 on trailing
    assign do_sample = cfg_i.cpha ? trail_edge : lead_edge;
    assign do_shift  = cfg_i.cpha ? (lead_edge && bit_cnt != '0) : (trail_edge && !last_bit);

    assign s_ready_o = (state == IDLE || state == HOLD) && m_ready_i && !rx_valid_q;
    assign load      = s_i.tvalid && s_ready_o;
    assign cs_active = (state == SETUP || state == SHIFT || state == HOLD);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state      <= IDLE;
            half_cnt   <= '0;
            wait_cnt   <= '0;
            bit_cnt    <= '0;
            phase_q    <= 1'b0;
            sel_q      <= '0;
            last_q     <= 1'b0;
            rx_valid_q <= 1'b0;
        end else begin
            if (rx_valid_q && m_ready_i) begin
                rx_valid_q <= 1'b0;
            end
            if ((state == SETUP || state == SHIFT) && !half_done) begin
                half_cnt <= half_cnt + 1'b1;
            end else begin
                half_cnt <= '0;
            end
            case (state)
                IDLE: begin
                    if (load) begin
                        sel_q  <= cfg_i.select;  // held for the frame
                        last_q <= s_i.tlast;
                        state  <= SETUP;
                    end
                end
                HOLD: begin
                    if (load) begin
                        last_q <= s_i.tlast;
                        state  <= SETUP;
                    end
                end
                SETUP: begin
                    if (lead_edge) begin
                        phase_q <= 1'b1;
                        state   <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (lead_edge) begin
                        phase_q <= 1'b1;
                    end
                    if (trail_edge) begin
                        phase_q <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_bit) begin
                            rx_valid_q <= 1'b1;
                            wait_cnt   <= '0;
                            state      <= last_q ? WAIT : HOLD;
                        end
                    end
                end
                WAIT: begin
                    if (wait_cnt == cfg_i.wait_time) begin
                        state <= IDLE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // MSB first
    always_ff @(posedge clk_i) begin
        if (load) begin
            tx_shift <= s_i.tdata;
        end else if (do_shift) begin
            tx_shift <= {tx_shift[`SPI_DATA_WIDTH-2:0], 1'b0};
        end
        if (do_sample) begin
            rx_shift <= {rx_shift[`SPI_DATA_WIDTH-2:0], miso_i};
        end
    end

    always_comb begin
        m_o.tdata  = rx_shift;
        m_o.tlast  = last_q;
        m_o.tvalid = rx_valid_q;
    end

    always_comb begin
        spi_o.sck  = cfg_i.cpol ^ phase_q;
        spi_o.mosi = tx_shift[`SPI_DATA_WIDTH-1];
        for (int i = 0; i < `SPI_SLAVE_NUM; i++) begin
            spi_o.cs_n[i] = !(cs_active && (sel_q == spi_sel_t'(i)));
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i)
        $countones(~spi_o.cs_n) <= 1);
    // no clock activity outside a frame
    assert property (@(posedge clk_i) disable iff (reset_i)
        &spi_o.cs_n |-> spi_o.sck == cfg_i.cpol);

endmodule

`default_nettype wire

// ==== hw/spi_pkg.sv ====
// types for the SPI controller: vector typedefs, AXI-lite, stream, config, status, port, FSM states
`default_nettype none
`include "spi_consts.svh"

package spi_pkg;

    typedef logic [`SPI_DATA_WIDTH-1:0]        spi_data_t;
    typedef logic [`SPI_DIV_WIDTH-1:0]         spi_div_t;  // half period minus one
    typedef logic [`SPI_WAIT_WIDTH-1:0]        spi_wait_t;
    typedef logic [$clog2(`SPI_SLAVE_NUM)-1:0] spi_sel_t;
    typedef logic [`AXIL_ADDR_WIDTH-1:0]       axil_addr_t;
    typedef logic [`AXIL_DATA_WIDTH-1:0]       axil_data_t;

    typedef struct packed {
        spi_data_t tdata;
        logic      tlast;
        logic      tvalid;
    } spi_stream_t;

    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

    // writable register bank
    typedef struct packed {
        logic      enable;
        logic      cpol;
        logic      cpha;
        spi_div_t  divider;
        spi_wait_t wait_time;
        spi_sel_t  select;
    } spi_cfg_t;

    typedef struct packed {
        logic rx_empty;
        logic tx_empty;
        logic rx_full;
        logic tx_full;
    } spi_status_t;

    typedef struct packed {
        logic                      sck;
        logic                      mosi;
        logic [`SPI_SLAVE_NUM-1:0] cs_n;
    } spi_port_t;

    typedef enum logic [2:0] {
        IDLE,
        SETUP,   // cs_n low, waiting for the first edge
        SHIFT,
        HOLD,    // between bytes of one frame
        WAIT
    } spi_state_e;

endpackage

`default_nettype wire

// ==== hw/spi_reg_file.sv ====
// AXI-lite slave with the SPI config registers, read mux, TX push and RX pop
`timescale 1ns/1ps
`default_nettype none
`include "spi_consts.svh"

module spi_reg_file (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire spi_pkg::axil_req_t   axil_req_i,
    output spi_pkg::axil_rsp_t        axil_rsp_o,
    input  wire spi_pkg::spi_status_t status_i,
    input  wire spi_pkg::spi_stream_t rx_i,
    output logic                      rx_ready_o,
    output spi_pkg::spi_stream_t      tx_o,
    input  wire logic                 tx_ready_i,
    output spi_pkg::spi_cfg_t         cfg_o
);
    import spi_pkg::*;

    logic       wr_en;
    logic       rd_en;
    logic       bvalid_q;
    logic       rvalid_q;
    axil_data_t rdata_q;
    axil_data_t rd_word;
    spi_cfg_t   cfg_q;

    assign wr_en = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
    assign rd_en = axil_req_i.arvalid && !rvalid_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            bvalid_q <= 1'b0;
            cfg_q    <= '{divider: spi_div_t'(1), default: '0};
        end else begin
            if (wr_en) begin
                bvalid_q <= 1'b1;
            end else if (axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end
            if (wr_en) begin
                case (axil_req_i.awaddr)
                    `SPI_REG_CONTROL: begin
                        cfg_q.enable <= axil_req_i.wdata[`SPI_CTRL_ENABLE];
                        cfg_q.cpol   <= axil_req_i.wdata[`SPI_CTRL_CPOL];
                        cfg_q.cpha   <= axil_req_i.wdata[`SPI_CTRL_CPHA];
                    end
                    `SPI_REG_DIVIDER: cfg_q.divider <= spi_div_t'(axil_req_i.wdata);
                    `SPI_REG_WAIT: cfg_q.wait_time <= spi_wait_t'(axil_req_i.wdata);
                    `SPI_REG_SELECT: cfg_q.select <= spi_sel_t'(axil_req_i.wdata);
                    default: ;
                endcase
            end
        end
    end

    // PARAM is {reg count[31:24], fifo depth[23:8], data width[7:0]}
    always_comb begin
        rd_word = '0;
        case (axil_req_i.araddr)
            `SPI_REG_CONTROL: begin
                rd_word[`SPI_CTRL_ENABLE] = cfg_q.enable;
                rd_word[`SPI_CTRL_CPOL]   = cfg_q.cpol;
                rd_word[`SPI_CTRL_CPHA]   = cfg_q.cpha;
            end
            `SPI_REG_STATUS: rd_word[$bits(spi_status_t)-1:0] = status_i;
            `SPI_REG_DIVIDER: rd_word[`SPI_DIV_WIDTH-1:0] = cfg_q.divider;
            `SPI_REG_WAIT: rd_word[`SPI_WAIT_WIDTH-1:0] = cfg_q.wait_time;
            `SPI_REG_SELECT: rd_word[$bits(spi_sel_t)-1:0] = cfg_q.select;
            `SPI_REG_RX: begin
                if (rx_i.tvalid) begin                  // empty fifo reads as 0
                    rd_word[`SPI_DATA_WIDTH-1:0] = rx_i.tdata;
                    rd_word[`SPI_RX_VALID]       = 1'b1;
                end
            end
            `SPI_REG_PARAM: begin
                rd_word = {8'(`SPI_REG_NUM), 16'(`SPI_FIFO_DEPTH), 8'(`SPI_DATA_WIDTH)};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rvalid_q <= 1'b0;
        end else if (rd_en) begin
            rvalid_q <= 1'b1;
        end else if (axil_req_i.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= rd_word;
        end
    end

    assign rx_ready_o = rd_en && (axil_req_i.araddr == `SPI_REG_RX);

    always_comb begin
        tx_o.tdata  = spi_data_t'(axil_req_i.wdata);
        tx_o.tlast  = axil_req_i.wdata[`SPI_TX_LAST];
        tx_o.tvalid = wr_en && (axil_req_i.awaddr == `SPI_REG_TX) && tx_ready_i; // dropped when full
    end

    always_comb begin
        axil_rsp_o.awready = wr_en;
        axil_rsp_o.wready  = wr_en;
        axil_rsp_o.bvalid  = bvalid_q;
        axil_rsp_o.bresp   = 2'b00;
        axil_rsp_o.arready = rd_en;
        axil_rsp_o.rvalid  = rvalid_q;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = 2'b00;
    end

    assign cfg_o = cfg_q;

    // responses hold until the manager takes them
    assert property (@(posedge clk_i) disable iff (reset_i)
        bvalid_q && !axil_req_i.bready |=> bvalid_q);
    assert property (@(posedge clk_i) disable iff (reset_i)
        rvalid_q && !axil_req_i.rready |=> rvalid_q && $stable(rdata_q));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the SPI controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_axil_spi -f build.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx '>>> PASS' <<< "$out"; then
    exit 0
else
    exit 1
fi

// ==== verif/tb_axil_spi.sv ====
// testbench for axil_spi: clock, reset, AXI-lite bus tasks, loopback, reference model, checks
`timescale 1ns/1ps
`default_nettype none
`include "spi_consts.svh"

module tb_axil_spi;
    import spi_pkg::*;

    localparam int WAIT_LIMIT = 2000;  // cycles per handshake
    localparam int POLL_LIMIT = 500;   // register polls per wait

    logic                      clk;
    logic                      reset;
    axil_req_t                 req;
    axil_rsp_t                 rsp;
    spi_port_t                 spi;
    logic [31:0]               rng_state;
    logic                      exp_cpol;
    logic [`SPI_SLAVE_NUM-1:0] cs_prev;
    int                        frames [`SPI_SLAVE_NUM];
    int                        idle_sck_bad;
    int                        checks;
    int                        errors;
    int                        tests;
    int                        failed_tests;
    int                        test_err_base;
    spi_data_t                 sent_q [$];

    axil_spi i_dut (
        .clk_i       (clk),
        .reset_i     (reset),
        .s_axil_req_i(req),
        .s_axil_rsp_o(rsp),
        .miso_i      (spi.mosi),  // loopback
        .spi_o       (spi)
    );

    always #2 clk = ~clk;

    // frame counter and idle sck level
    always @(negedge clk) begin
        if (!reset) begin
            for (int i = 0; i < `SPI_SLAVE_NUM; i++) begin
                if (cs_prev[i] && !spi.cs_n[i]) begin
                    frames[i] = frames[i] + 1;
                end
            end
            if (&spi.cs_n && spi.sck !== exp_cpol) begin
                idle_sck_bad = idle_sck_bad + 1;
            end
        end
        cs_prev = spi.cs_n;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic spi_data_t random_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[7:0];
    endfunction

    // mosi is wired to miso, so every byte comes back unchanged
    function automatic spi_data_t expected_rx(input spi_data_t sent);
        return sent;
    endfunction

    function automatic spi_status_t make_status(input logic rx_e, input logic tx_e,
                                                input logic rx_f, input logic tx_f);
        spi_status_t s;
        s.rx_empty = rx_e;
        s.tx_empty = tx_e;
        s.rx_full  = rx_f;
        s.tx_full  = tx_f;
        return s;
    endfunction

    task automatic abort_run(input string what);
        $display("Run stopped at %0t ns: timed out waiting for %s", $time, what);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic check_data(input string what, input spi_data_t got, input spi_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input string what, input spi_status_t got,
                                input spi_status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input axil_data_t got, input axil_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
        int n;
        @(posedge clk);
        req.awaddr  <= addr;
        req.awvalid <= 1'b1;
        req.wdata   <= data;
        req.wvalid  <= 1'b1;
        req.bready  <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) abort_run("awready and wready");
        end while (!(rsp.awready && rsp.wready));
        @(posedge clk);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) abort_run("bvalid");
        end while (!rsp.bvalid);
        check_word($sformatf("bresp of write to 0x%02h", addr), axil_data_t'(rsp.bresp), '0);
        @(posedge clk);
        req.bready <= 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
        int n;
        @(posedge clk);
        req.araddr  <= addr;
        req.arvalid <= 1'b1;
        req.rready  <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) abort_run("arready");
        end while (!rsp.arready);
        @(posedge clk);
        req.arvalid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) abort_run("rvalid");
        end while (!rsp.rvalid);
        data = rsp.rdata;
        check_word($sformatf("rresp of read from 0x%02h", addr), axil_data_t'(rsp.rresp), '0);
        @(posedge clk);
        req.rready <= 1'b0;
    endtask

    task automatic send_byte(input spi_data_t data, input logic last);
        axil_write(`SPI_REG_TX, {23'b0, last, data});
    endtask

    // polls RX until the valid bit shows
    task automatic read_rx(output spi_data_t data);
        axil_data_t word;
        int         polls;
        polls = 0;
        word  = '0;
        while (!word[`SPI_RX_VALID]) begin
            if (polls == POLL_LIMIT) abort_run("an RX byte");
            axil_read(`SPI_REG_RX, word);
            polls++;
        end
        data = word[`SPI_DATA_WIDTH-1:0];
    endtask

    task automatic wait_status(input spi_status_t mask, input string what);
        axil_data_t word;
        int         polls;
        polls = 0;
        axil_read(`SPI_REG_STATUS, word);
        while ((spi_status_t'(word[$bits(spi_status_t)-1:0]) & mask) != mask) begin
            if (polls == POLL_LIMIT) abort_run(what);
            axil_read(`SPI_REG_STATUS, word);
            polls++;
        end
    endtask

    task automatic read_status(output spi_status_t st);
        axil_data_t word;
        axil_read(`SPI_REG_STATUS, word);
        st = word[$bits(spi_status_t)-1:0];
    endtask

    task automatic begin_test();
        test_err_base = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_err_base) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, name, errors - test_err_base);
        end
    endtask

    initial begin
        axil_data_t  word;
        axil_data_t  param_exp;
        spi_status_t st;
        spi_data_t   d;
        int          base [`SPI_SLAVE_NUM];
        int          sck_base;
        clk       = 1'b0;
        reset    <= 1'b1;
        req      <= '0;
        rng_state = 32'd45785;
        exp_cpol  = 1'b0;
        checks    = 0;
        errors    = 0;
        tests     = 0;
        failed_tests = 0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        begin_test();
        read_status(st);
        check_status("status after reset", st, make_status(1'b1, 1'b1, 1'b0, 1'b0));
        param_exp = {8'd8, 16'd16, 8'd8};  // reg count 8, depth 16, width 8
        axil_read(`SPI_REG_PARAM, word);
        check_word("param", word, param_exp);
        @(negedge clk);
        check_word("idle sck", axil_data_t'(spi.sck), '0);
        check_word("idle cs_n", axil_data_t'(spi.cs_n), axil_data_t'({`SPI_SLAVE_NUM{1'b1}}));
        end_test("reset state");

        begin_test();
        for (int mode = 0; mode < 4; mode++) begin
            axil_write(`SPI_REG_CONTROL, axil_data_t'(1 + 2 * (mode % 2) + 4 * (mode / 2)));
            exp_cpol = logic'(mode % 2);
            sck_base = idle_sck_bad;
            sent_q.delete();
            for (int b = 0; b < 4; b++) begin
                d = random_byte();
                sent_q.push_back(d);
                send_byte(d, b == 3);
            end
            for (int b = 0; b < 4; b++) begin
                read_rx(d);
                check_data($sformatf("mode %0d byte %0d", mode, b), d, expected_rx(sent_q[b]));
            end
            check_word($sformatf("mode %0d idle sck errors", mode),
                       axil_data_t'(idle_sck_bad - sck_base), '0);
        end
        end_test("cpol/cpha modes");

        begin_test();
        axil_write(`SPI_REG_CONTROL, 32'h1);
        exp_cpol = 1'b0;
        axil_write(`SPI_REG_WAIT, 32'd3);
        base = frames;
        sent_q.delete();
        for (int b = 0; b < 6; b++) begin
            d = random_byte();
            sent_q.push_back(d);
            send_byte(d, b == 1 || b == 5);  // frames end on bytes 2 and 6
        end
        for (int b = 0; b < 6; b++) begin
            read_rx(d);
            check_data($sformatf("frame byte %0d", b), d, expected_rx(sent_q[b]));
        end
        check_word("frames on cs 0", axil_data_t'(frames[0] - base[0]), 32'd2);
        check_word("frames on cs 1", axil_data_t'(frames[1] - base[1]), 32'd0);
        axil_write(`SPI_REG_SELECT, 32'd1);
        base = frames;
        sent_q.delete();
        for (int b = 0; b < 2; b++) begin
            d = random_byte();
            sent_q.push_back(d);
            send_byte(d, b == 1);
        end
        for (int b = 0; b < 2; b++) begin
            read_rx(d);
            check_data($sformatf("select 1 byte %0d", b), d, expected_rx(sent_q[b]));
        end
        check_word("select 1 frames on cs 0", axil_data_t'(frames[0] - base[0]), 32'd0);
        check_word("select 1 frames on cs 1", axil_data_t'(frames[1] - base[1]), 32'd1);
        axil_write(`SPI_REG_SELECT, 32'd0);
        end_test("framing");

        begin_test();
        axil_write(`SPI_REG_DIVIDER, 32'd0);
        axil_write(`SPI_REG_WAIT, 32'd0);
        sent_q.delete();
        for (int b = 0; b < 20; b++) begin
            d = random_byte();
            sent_q.push_back(d);
            send_byte(d, 1'b1);
        end
        wait_status(make_status(1'b0, 1'b0, 1'b1, 1'b0), "rx_full");
        read_status(st);
        check_status("status with rx full", st, make_status(1'b0, 1'b0, 1'b1, 1'b0));
        for (int b = 0; b < `SPI_FIFO_DEPTH - (20 - `SPI_FIFO_DEPTH); b++) begin
            d = random_byte();
            sent_q.push_back(d);
            send_byte(d, 1'b1);
        end
        read_status(st);
        check_status("status with both full", st, make_status(1'b0, 1'b0, 1'b1, 1'b1));
        send_byte(random_byte(), 1'b1);  // lost because the tx fifo is full
        for (int b = 0; b < sent_q.size(); b++) begin
            read_rx(d);
            check_data($sformatf("back-pressure byte %0d", b), d, expected_rx(sent_q[b]));
        end
        axil_read(`SPI_REG_RX, word);
        check_word("rx after drain", word, '0);
        end_test("back-pressure");

        begin_test();
        axil_write(`SPI_REG_DIVIDER, 32'd4);
        for (int b = 0; b < 3; b++) begin
            send_byte(random_byte(), b == 2);
        end
        axil_write(`SPI_REG_CONTROL, 32'h0);
        read_status(st);
        check_status("status in soft reset", st, make_status(1'b1, 1'b1, 1'b0, 1'b0));
        @(negedge clk);
        check_word("cs_n in soft reset", axil_data_t'(spi.cs_n),
                   axil_data_t'({`SPI_SLAVE_NUM{1'b1}}));
        axil_write(`SPI_REG_CONTROL, 32'h1);
        sent_q.delete();
        sent_q.push_back(random_byte());
        send_byte(sent_q[0], 1'b1);
        read_rx(d);
        check_data("byte after re-enable", d, expected_rx(sent_q[0]));
        end_test("soft reset");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
